//--- compile.f
rtl/mem_pkg.sv
rtl/cache_pkg.sv
rtl/data_memory.sv
rtl/cache_store.sv
rtl/cache_controller.sv
rtl/memory_subsystem.sv
testbench/clock_gen.sv
testbench/memory_subsystem_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the memory subsystem testbench with Verilator, runs it and checks the log

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
TOP=memory_subsystem_tb

verilator --binary --timing --assert -f compile.f --top-module "$TOP" --Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "Testbench passed" "$LOG_FILE"; then
	exit 0
fi
echo "Pass message not found in $LOG_FILE"
exit 1

//--- testbench/memory_subsystem_tb.sv
//------------------------------
// Testbench of the data-side memory subsystem
// Applies a request table and LFSR requests through req/ack and checks reads
// against a model of the word memory
//------------------------------

`timescale 1ns/1ps

module memory_subsystem_tb
	import mem_pkg::*, cache_pkg::*;
();

	localparam int LINE_BITS = 2;
	localparam int DELAY_BITS = 3;
	localparam int TEST_WORDS = 64;
	localparam int RANDOM_REQUESTS = 64;
	localparam int WAIT_LIMIT = 64;
	localparam int RESET_LIMIT = 20;

	// One request with the read value that the model expects for it
	typedef struct packed {
		logic write;
		word_addr_t addr;
		word_t wdata;
		word_t expected;
	} table_row_t;

	logic clock;
	logic reset;
	logic req;
	cpu_req_t cpu_req;
	logic ack;
	word_t rdata;

	table_row_t request_table [$];
	// Model of every word, indexed by the full word address
	word_t model [mem_blocks*words_per_block];
	logic [31:0] lfsr;
	int check_count;
	int error_count;
	int timeout_count;
	logic timed_out;
	int row_index;

	clock_gen i_clock_gen (.clock(clock), .reset(reset));

	memory_subsystem #(.LINE_BITS(LINE_BITS), .DELAY_BITS(DELAY_BITS)) i_memory_subsystem (
		.clock(clock), .reset(reset), .req(req), .cpu_req(cpu_req),
		.ack(ack), .rdata(rdata)
	);

	// Write data carries a round number and the whole word address
	function automatic word_t pattern_word(input word_addr_t addr, input logic [7:0] round);
		return {round, 8'h3c, 6'h00, addr};
	endfunction

	// Galois LFSR step, taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		if (state[0])
			return (state >> 1) ^ 32'h8020_0003;
		return state >> 1;
	endfunction

	// Shifts count LFSR output bits into value, one step per bit
	task automatic take_bits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			value = {value[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// Appends one request; the model answers reads and follows writes
	task automatic add_row(input logic write, input word_addr_t addr, input word_t wdata);
		table_row_t row;
		row.write = write;
		row.addr = addr;
		row.wdata = wdata;
		if (write)
			model[addr] = wdata;
		row.expected = model[addr];
		request_table.push_back(row);
	endtask

	task automatic build_table();
		int a;
		// Every test word gets a value before any read
		for (a = 0; a < TEST_WORDS; a++)
			add_row(1'b1, word_addr_t'(a), pattern_word(word_addr_t'(a), 8'h01));
		for (a = 0; a < TEST_WORDS; a++)
			add_row(1'b0, word_addr_t'(a), '0);
		// Word 5 changes, its block neighbors 4, 6 and 7 must not
		add_row(1'b1, 10'd5, pattern_word(10'd5, 8'h02));
		add_row(1'b0, 10'd4, '0);
		add_row(1'b0, 10'd6, '0);
		add_row(1'b0, 10'd7, '0);
		add_row(1'b0, 10'd5, '0);
		// Blocks 0, 4 and 8 all map to line 0 and evict each other
		for (a = 0; a < 3; a++)
		begin
			add_row(1'b0, 10'd1, '0);
			add_row(1'b0, 10'd17, '0);
			add_row(1'b0, 10'd33, '0);
		end
		add_row(1'b1, 10'd17, pattern_word(10'd17, 8'h03));
		add_row(1'b0, 10'd1, '0);
		add_row(1'b0, 10'd17, '0);
		// Back-to-back accesses inside block 10, mostly hits
		add_row(1'b0, 10'd40, '0);
		add_row(1'b0, 10'd41, '0);
		add_row(1'b0, 10'd42, '0);
		add_row(1'b0, 10'd43, '0);
		add_row(1'b1, 10'd41, pattern_word(10'd41, 8'h04));
		add_row(1'b1, 10'd42, pattern_word(10'd42, 8'h04));
		add_row(1'b0, 10'd41, '0);
		add_row(1'b0, 10'd42, '0);
		add_row(1'b0, 10'd40, '0);
		add_row(1'b1, 10'd43, pattern_word(10'd43, 8'h05));
		add_row(1'b0, 10'd43, '0);
	endtask

	// Random mix in words 0 to 63, after the fixed rows
	task automatic add_random_rows();
		logic [31:0] write_bits;
		logic [31:0] addr_bits;
		logic [31:0] data_bits;
		for (int i = 0; i < RANDOM_REQUESTS; i++)
		begin
			take_bits(1, write_bits);
			take_bits(6, addr_bits);
			take_bits(32, data_bits);
			add_row(write_bits[0], {4'b0000, addr_bits[5:0]}, data_bits);
		end
	endtask

	task automatic wait_for_reset();
		int cycles;
		cycles = 0;
		while (reset !== 1'b1 && cycles < RESET_LIMIT)
		begin
			@(negedge clock);
			cycles++;
		end
		if (reset !== 1'b1)
		begin
			timeout_count++;
			timed_out = 1'b1;
			$display("Timeout: reset was not released within %0d cycles", RESET_LIMIT);
		end
	endtask

	// One full four-phase transfer; inputs change on rising edges, outputs
	// are sampled on falling edges
	task automatic apply_row(input table_row_t row);
		cpu_req_t next_req;
		int cycles;
		next_req.write = row.write;
		next_req.addr = row.addr;
		next_req.wdata = row.wdata;
		@(posedge clock);
		cpu_req <= next_req;
		req <= 1'b1;
		cycles = 0;
		@(negedge clock);
		while (!ack && cycles < WAIT_LIMIT)
		begin
			@(negedge clock);
			cycles++;
		end
		if (!ack)
		begin
			timeout_count++;
			timed_out = 1'b1;
			$display("Timeout: ack did not rise within %0d cycles for word %0d",
				WAIT_LIMIT, row.addr);
			return;
		end
		if (!row.write)
		begin
			check_count++;
			assert (rdata === row.expected)
			else
			begin
				error_count++;
				$display("[ERROR] %0t: read of word %0d returned %h, expected %h",
					$time, row.addr, rdata, row.expected);
			end
		end
		@(posedge clock);
		req <= 1'b0;
		cycles = 0;
		@(negedge clock);
		while (ack && cycles < WAIT_LIMIT)
		begin
			@(negedge clock);
			cycles++;
		end
		if (ack)
		begin
			timeout_count++;
			timed_out = 1'b1;
			$display("Timeout: ack did not fall within %0d cycles for word %0d",
				WAIT_LIMIT, row.addr);
		end
	endtask

	initial
	begin
		req = 1'b0;
		cpu_req = '0;
		lfsr = 32'h6d57;
		check_count = 0;
		error_count = 0;
		timeout_count = 0;
		timed_out = 1'b0;
		build_table();
		add_random_rows();
		wait_for_reset();
		// No acknowledge may appear before the first request
		if (!timed_out)
		begin
			@(negedge clock);
			check_count++;
			assert (ack === 1'b0)
			else
			begin
				error_count++;
				$display("[ERROR] %0t: ack is %b after reset, expected 0", $time, ack);
			end
		end
		for (row_index = 0; row_index < request_table.size() && !timed_out; row_index++)
			apply_row(request_table[row_index]);
		$display("Checks: %0d, value errors: %0d, timeouts: %0d",
			check_count, error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0 && check_count > 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

//--- testbench/clock_gen.sv
//------------------------------
// Clock and reset source of the testbench
// 40 ns clock, reset held low for the first 4 rising edges
//------------------------------

`timescale 1ns/1ps

module clock_gen
#(
	parameter int HALF_PERIOD_NS = 20,
	parameter int RESET_CYCLES = 4
)
(
	output logic clock,
	output logic reset
);

	// Free-running clock, low at time zero
	initial
	begin
		clock = 1'b0;
		forever #HALF_PERIOD_NS clock = ~clock;
	end

	// Reset is released on a rising edge, like any other driven input
	initial
	begin
		reset = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b1;
	end

endmodule

//--- rtl/memory_subsystem.sv
//------------------------------
// Top of the data side: controller, cache lines and block memory
// The processor talks to it through req and ack only
//------------------------------

`timescale 1ns/1ps

module memory_subsystem
	import mem_pkg::*, cache_pkg::*;
#(
	parameter int LINE_BITS = 2,
	parameter int DELAY_BITS = 3
)
(
	input logic clock,
	input logic reset,
	input logic req,
	input cpu_req_t cpu_req,
	output logic ack,
	output word_t rdata
);

	// Controller to cache store
	logic [LINE_BITS-1:0] lookup_index;
	logic [$bits(block_addr_t)-LINE_BITS-1:0] lookup_tag;
	logic hit;
	block_t line_block;
	logic fill_en;
	logic [LINE_BITS-1:0] fill_index;
	logic [$bits(block_addr_t)-LINE_BITS-1:0] fill_tag;
	block_t fill_block;

	// Controller to data memory
	logic ren;
	logic wen;
	block_addr_t block_address;
	block_t din;
	logic ready;
	logic done;
	block_t dout;

	cache_controller #(.LINE_BITS(LINE_BITS)) i_cache_controller (
		.clock(clock), .reset(reset), .req(req), .cpu_req(cpu_req),
		.ack(ack), .rdata(rdata), .hit(hit), .line_block(line_block),
		.lookup_index(lookup_index), .lookup_tag(lookup_tag),
		.fill_en(fill_en), .fill_index(fill_index), .fill_tag(fill_tag),
		.fill_block(fill_block), .ren(ren), .wen(wen),
		.block_address(block_address), .din(din),
		.ready(ready), .done(done), .dout(dout)
	);

	cache_store #(.LINE_BITS(LINE_BITS)) i_cache_store (
		.clock(clock), .reset(reset),
		.lookup_index(lookup_index), .lookup_tag(lookup_tag),
		.hit(hit), .line_block(line_block),
		.fill_en(fill_en), .fill_index(fill_index), .fill_tag(fill_tag),
		.fill_block(fill_block)
	);

	data_memory #(.DELAY_BITS(DELAY_BITS)) i_data_memory (
		.clock(clock), .reset(reset), .ren(ren), .wen(wen),
		.block_address(block_address), .din(din),
		.ready(ready), .done(done), .dout(dout)
	);

endmodule

//--- rtl/cache_controller.sv
//------------------------------
// Data cache controller that serves one processor request at a time
// Reads hit or fetch, and writes merge into the block and write through
//------------------------------

`timescale 1ns/1ps

module cache_controller
	import mem_pkg::*, cache_pkg::*;
#(
	parameter int LINE_BITS = 2
)
(
	input logic clock,
	input logic reset,
	input logic req,
	input cpu_req_t cpu_req,
	output logic ack,
	output word_t rdata,
	input logic hit,
	input block_t line_block,
	output logic [LINE_BITS-1:0] lookup_index,
	output logic [$bits(block_addr_t)-LINE_BITS-1:0] lookup_tag,
	output logic fill_en,
	output logic [LINE_BITS-1:0] fill_index,
	output logic [$bits(block_addr_t)-LINE_BITS-1:0] fill_tag,
	output block_t fill_block,
	output logic ren,
	output logic wen,
	output block_addr_t block_address,
	output block_t din,
	input logic ready,
	input logic done,
	input block_t dout
);

	localparam int TAG_BITS = $bits(block_addr_t) - LINE_BITS;

	typedef logic [LINE_BITS-1:0] line_index_t;
	typedef logic [TAG_BITS-1:0] line_tag_t;

	ctrl_state_t state;

	// The request as it was when req rose
	cpu_req_t req_q;

	// Working copy of the block that holds the line, the fetched or the merged data
	block_t block_q;

	// Fields of the latched address
	block_addr_t req_block;
	word_offset_t req_offset;
	line_index_t req_index;
	line_tag_t req_tag;

	assign req_block = req_q.addr[$bits(word_addr_t)-1 -: $bits(block_addr_t)];
	assign req_offset = req_q.addr[$bits(word_offset_t)-1:0];
	assign req_index = req_block[LINE_BITS-1:0];
	assign req_tag = req_block[$bits(block_addr_t)-1:LINE_BITS];

	// Control state and the acknowledge
	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			state <= idle;
			ack <= 1'b0;
		end
		else
		begin
			case (state)
				idle:
					if (req)
						state <= lookup;
				lookup:
					// A write always goes through memory while a read hit does not
					if (!hit)
						state <= fetch;
					else if (req_q.write)
						state <= merge;
					else
						state <= respond;
				fetch:
					// ren drops the cycle after ready is seen
					if (ready)
						state <= fetch_release;
				fetch_release:
					if (req_q.write)
						state <= merge;
					else
						state <= respond;
				merge:
					state <= write_mem;
				write_mem:
					if (done)
						state <= write_release;
				write_release:
					state <= respond;
				respond:
					// Four-phase end that raises ack and then waits for req to fall
					if (!ack)
						ack <= 1'b1;
					else if (!req)
					begin
						ack <= 1'b0;
						state <= idle;
					end
				default:
					state <= idle;
			endcase
		end
	end

	// Request and block registers follow the state machine
	always_ff @(posedge clock)
	begin
		case (state)
			idle:
				if (req)
					req_q <= cpu_req;
			lookup:
				block_q <= line_block;
			fetch:
				// dout is still valid here because ren is still held
				if (ready)
					block_q <= dout;
			merge:
				block_q[req_offset*$bits(word_t) +: $bits(word_t)] <= req_q.wdata;
			default:
				block_q <= block_q;
		endcase
	end

	// The store is always looked up with the latched address
	assign lookup_index = req_index;
	assign lookup_tag = req_tag;

	// Lines are filled after a fetch and again after a write-through
	assign fill_en = (state == fetch_release) || (state == write_release);
	assign fill_index = req_index;
	assign fill_tag = req_tag;
	assign fill_block = block_q;

	// Only one enable per state and both stay low in the release states
	assign ren = (state == fetch);
	assign wen = (state == write_mem);
	assign block_address = req_block;
	assign din = block_q;

	// The addressed word stays stable from ack rising until the next request
	assign rdata = block_q[req_offset*$bits(word_t) +: $bits(word_t)];

	// The processor side must be asking before it is answered
	assert property (@(posedge clock) disable iff (!reset) $rose(ack) |-> req)
		else $error("cache_controller: ack rose without req");

	// The memory answers only an access that was held in the cycle before
	assert property (@(posedge clock) disable iff (!reset)
		(ready || done) |-> $past(ren || wen))
		else $error("cache_controller: memory answered without an access");

endmodule

//--- rtl/cache_store.sv
//------------------------------
// Direct-mapped line storage of the data cache
// Lookup is combinational, a fill is written at the next clock edge
//------------------------------

`timescale 1ns/1ps

module cache_store
	import mem_pkg::*;
#(
	parameter int LINE_BITS = 2
)
(
	input logic clock,
	input logic reset,
	input logic [LINE_BITS-1:0] lookup_index,
	input logic [$bits(block_addr_t)-LINE_BITS-1:0] lookup_tag,
	output logic hit,
	output block_t line_block,
	input logic fill_en,
	input logic [LINE_BITS-1:0] fill_index,
	input logic [$bits(block_addr_t)-LINE_BITS-1:0] fill_tag,
	input block_t fill_block
);

	// The tag is the block address bits above the line index
	localparam int LINES = 2**LINE_BITS;
	localparam int TAG_BITS = $bits(block_addr_t) - LINE_BITS;

	typedef logic [TAG_BITS-1:0] line_tag_t;

	// One valid bit per line, all lines start empty
	logic [LINES-1:0] valid;

	// Tags and data of each line
	line_tag_t tag_array [LINES];
	block_t block_array [LINES];

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
			valid <= '0;
		else if (fill_en)
			valid[fill_index] <= 1'b1;
	end

	// A fill replaces tag and data together
	always_ff @(posedge clock)
	begin
		if (fill_en)
		begin
			tag_array[fill_index] <= fill_tag;
			block_array[fill_index] <= fill_block;
		end
	end

	// A hit needs a valid line whose stored tag matches
	assign hit = valid[lookup_index] && (tag_array[lookup_index] == lookup_tag);

	// The line data is offered whether or not it hits
	assign line_block = block_array[lookup_index];

endmodule

//--- rtl/data_memory.sv
//------------------------------
// Slow block memory behind the data cache
// Hold ren or wen high with a stable address, then wait for ready or done
//------------------------------

`timescale 1ns/1ps

module data_memory
	import mem_pkg::*;
#(
	parameter int DELAY_BITS = 3
)
(
	input logic clock,
	input logic reset,
	input logic ren,
	input logic wen,
	input block_addr_t block_address,
	input block_t din,
	output logic ready,
	output logic done,
	output block_t dout
);

	// Block storage, loaded only by writes
	block_t mem_array [mem_blocks];

	// Access delay counter, it climbs to all ones and holds there
	logic [DELAY_BITS-1:0] delay_count;
	logic delayed;
	logic counter_clear;

	// Unregistered completion flags, one cycle ahead of ready and done
	logic ready_int;
	logic done_int;

	// Write data is taken once, on the first cycle of a write
	block_t captured_din;
	logic din_captured;

	// The count restarts whenever no single access is pending
	assign counter_clear = (ren == wen);
	assign delayed = &delay_count;

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
			delay_count <= '0;
		else if (counter_clear)
			delay_count <= '0;
		else if (!delayed)
			delay_count <= delay_count + 1'b1;
	end

	assign ready_int = delayed && ren && !wen;
	assign done_int = delayed && wen && !ren;

	// The handshake outputs lag the internal flags by one cycle
	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			ready <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			ready <= ready_int;
			done <= done_int;
		end
	end

	// A held read keeps the counter at all ones, so dout stays valid
	assign dout = ready_int ? mem_array[block_address] : '0;

	// Marks that the current write already has its data
	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
			din_captured <= 1'b0;
		else
			din_captured <= wen && !ren;
	end

	always_ff @(posedge clock)
	begin
		if (wen && !ren && !din_captured)
			captured_din <= din;
	end

	// The captured block lands on the last counting cycle
	always_ff @(posedge clock)
	begin
		if (done_int)
			mem_array[block_address] <= captured_din;
	end

	// The controller must never request a read and a write at once
	assert property (@(posedge clock) disable iff (!reset) !(ren && wen))
		else $error("data_memory: ren and wen both active");

endmodule

//--- rtl/cache_pkg.sv
//------------------------------
// Cache side definitions: the processor request and the controller states
// Tag and index widths depend on the line count, so the cache modules type them
//------------------------------

package cache_pkg;

	import mem_pkg::*;

	// One processor request, held stable by the requester until ack rises
	typedef struct packed {
		// High for a word write, low for a word read
		logic write;
		// Word address inside the data memory
		word_addr_t addr;
		// Write data, ignored on reads
		word_t wdata;
	} cpu_req_t;

	// Controller states, from request latch to the end of the acknowledge
	typedef enum logic [2:0] {
		idle,
		lookup,
		fetch,
		fetch_release,
		merge,
		write_mem,
		write_release,
		respond
	} ctrl_state_t;

endpackage

//--- rtl/mem_pkg.sv
//------------------------------
// Memory geometry shared by the whole data side: word, block and address types
// Import into any module that moves words or blocks between cache and memory
//------------------------------

package mem_pkg;

	// One processor data word
	typedef logic [31:0] word_t;

	// Words held in each memory block and each cache line
	localparam int words_per_block = 4;

	// A whole block travels as one flat vector, word 0 in the low bits
	typedef logic [words_per_block*$bits(word_t)-1:0] block_t;

	// Position of a word inside its block
	typedef logic [$clog2(words_per_block)-1:0] word_offset_t;

	// Number of blocks in the backing memory
	localparam int mem_blocks = 256;

	typedef logic [$clog2(mem_blocks)-1:0] block_addr_t;

	// Word address: block address on top, word offset below
	typedef logic [$bits(block_addr_t)+$bits(word_offset_t)-1:0] word_addr_t;

endpackage
